/* list.f */
+incdir+include
rtl/cube_pkg.sv
rtl/display_timings.sv
rtl/draw_line.sv
rtl/cube_drawer.sv
rtl/framebuffer.sv
rtl/cube_display_top.sv
testbench/tb_cube_display.sv

/* rtl/cube_display_top.sv */
// cube drawer and raster scan sharing one framebuffer on a single clock
// video outputs lag the raster counters by one cycle
`timescale 1ns/1ps

module cube_display_top import cube_pkg::*; (
    input  logic             clk_100m,
    input  logic             arst_n,
    input  logic             redraw,        // one-cycle pulse
    input  logic [CIDXW-1:0] draw_cidx,
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output logic [CHANW-1:0] red,
    output logic [CHANW-1:0] green,
    output logic [CHANW-1:0] blue,
    output logic             busy,
    output logic             finished
);

    logic signed [CORDW-1:0] sx, sy;
    logic                    tim_hsync, tim_vsync, tim_de;  // undelayed
    logic                    frame;
    logic                    fb_we;
    logic signed [CORDW-1:0] fb_wx, fb_wy;
    logic [CIDXW-1:0]        fb_wcidx;

    display_timings display_timings_inst (
        .clk_100m (clk_100m),
        .arst_n   (arst_n),
        .sx       (sx),
        .sy       (sy),
        .hsync    (tim_hsync),
        .vsync    (tim_vsync),
        .de       (tim_de),
        .frame    (frame),
        .line     ()            // not needed at scale 1
    );

    cube_drawer cube_drawer_inst (
        .clk_100m  (clk_100m),
        .arst_n    (arst_n),
        .frame     (frame),
        .redraw    (redraw),
        .draw_cidx (draw_cidx),
        .we        (fb_we),
        .wx        (fb_wx),
        .wy        (fb_wy),
        .wcidx     (fb_wcidx),
        .busy      (busy),
        .finished  (finished)
    );

    framebuffer framebuffer_inst (
        .clk_100m (clk_100m),
        .arst_n   (arst_n),
        .we       (fb_we),
        .wx       (fb_wx),
        .wy       (fb_wy),
        .wcidx    (fb_wcidx),
        .sx       (sx),
        .sy       (sy),
        .de_in    (tim_de),
        .hsync_in (tim_hsync),
        .vsync_in (tim_vsync),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de)
    );

endmodule

/* rtl/cube_drawer.sv */
// walks the cube edge table once per pass, gated by the frame strobe
// a redraw only counts once the previous pass has finished
`timescale 1ns/1ps

module cube_drawer import cube_pkg::*; (
    input  logic                    clk_100m,
    input  logic                    arst_n,
    input  logic                    frame,
    input  logic                    redraw,
    input  logic [CIDXW-1:0]        draw_cidx,
    output logic                    we,
    output logic signed [CORDW-1:0] wx,
    output logic signed [CORDW-1:0] wy,
    output logic [CIDXW-1:0]        wcidx,
    output logic                    busy,
    output logic                    finished
);

    enum logic [2:0] {WAIT_FRAMES, IDLE, INIT, DRAW, DONE} state;

    logic [$clog2(DRAW_WAIT+1)-1:0] wait_cnt;
    logic [$clog2(LINE_CNT)-1:0]    line_id;
    logic                           draw_start;
    logic                           draw_done;
    logic signed [CORDW-1:0]        lx0, ly0, lx1, ly1;

    // edge coordinates straight from the table, latched by draw_line on start
    assign lx0 = CUBE_EDGES[line_id][0];
    assign ly0 = CUBE_EDGES[line_id][1];
    assign lx1 = CUBE_EDGES[line_id][2];
    assign ly1 = CUBE_EDGES[line_id][3];

    assign draw_start = (state == INIT);    // the one setup cycle per edge
    assign busy       = (state == INIT) || (state == DRAW);
    assign finished   = (state == DONE);

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state    <= WAIT_FRAMES;
            wait_cnt <= '0;
            line_id  <= '0;
            wcidx    <= DRAW_CIDX;
        end else begin
            case (state)
                WAIT_FRAMES: begin
                    if (frame) begin
                        if (wait_cnt == DRAW_WAIT - 1) begin
                            state <= IDLE;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                end
                IDLE: begin
                    line_id <= '0;
                    if (frame) state <= INIT;   // pass starts on a frame boundary
                end
                INIT: state <= DRAW;
                DRAW: begin
                    if (draw_done) begin
                        if (line_id == LINE_CNT - 1) begin
                            state <= DONE;
                        end else begin
                            line_id <= line_id + 1'b1;
                            state   <= INIT;
                        end
                    end
                end
                default: begin  // DONE
                    if (redraw) begin
                        wcidx <= draw_cidx;     // colour for the next pass
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    draw_line draw_line_inst (
        .clk_100m (clk_100m),
        .arst_n   (arst_n),
        .start    (draw_start),
        .x0       (lx0),
        .y0       (ly0),
        .x1       (lx1),
        .y1       (ly1),
        .x        (wx),
        .y        (wy),
        .drawing  (we),         // every point is a write
        .done     (draw_done)
    );

endmodule

/* rtl/cube_pkg.sv */
// shared constants for the cube display, single clock at one pixel per cycle
// edge table assumes a 160x90 framebuffer, palette entries are 12-bit rgb
package cube_pkg;

    localparam int CORDW = 16;      // signed screen coordinates
    localparam int CIDXW = 4;       // colour index width
    localparam int CHANW = 4;       // bits per colour channel

    // framebuffer geometry
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 90;
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = 14;

    // raster timing, syncs active high
    localparam int H_ACTIVE = 160;
    localparam int H_FRONT  = 8;
    localparam int H_SYNC   = 16;
    localparam int H_BACK   = 16;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 200
    localparam int V_ACTIVE = 90;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 3;
    localparam int V_BACK   = 5;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 100

    localparam int DRAW_WAIT = 3;   // frames to let pass after reset
    localparam int LINE_CNT  = 9;   // cube edges
    localparam logic [CIDXW-1:0] DRAW_CIDX = CIDXW'(8);  // red after reset

    // x0, y0, x1, y1 per edge
    localparam logic signed [CORDW-1:0] CUBE_EDGES [LINE_CNT][4] = '{
        '{ 65, 30, 115, 30},    // front face
        '{115, 30, 115, 80},
        '{115, 80,  65, 80},
        '{ 65, 80,  65, 30},
        '{ 65, 80,  45, 60},    // receding edges and back face
        '{ 45, 60,  45, 10},
        '{ 45, 10,  65, 30},
        '{ 45, 10,  95, 10},
        '{ 95, 10, 115, 30}
    };

    // red, green, blue nibbles
    localparam logic [3*CHANW-1:0] PALETTE [2**CIDXW] = '{
        12'h000, 12'h223, 12'h725, 12'h075,
        12'h942, 12'h344, 12'hccc, 12'hfff,
        12'hf05, 12'hf80, 12'hfe3, 12'h0e4,
        12'h3af, 12'h879, 12'hf7a, 12'hfca
    };

endpackage

/* rtl/display_timings.sv */
// raster counters and sync strobes, all outputs registered
// counters sit on the last position in reset so the first frame starts cleanly
`timescale 1ns/1ps

module display_timings import cube_pkg::*; (
    input  logic                    clk_100m,
    input  logic                    arst_n,
    output logic signed [CORDW-1:0] sx,
    output logic signed [CORDW-1:0] sy,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output logic                    frame,
    output logic                    line
);

    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    logic signed [CORDW-1:0] sx_nxt;
    logic signed [CORDW-1:0] sy_nxt;
    logic                    line_end;
    logic                    frame_end;

    assign line_end  = (sx == H_TOTAL - 1);
    assign frame_end = (sy == V_TOTAL - 1);

    // next raster position, flags below are decoded from it
    always_comb begin
        sx_nxt = line_end ? '0 : sx + CORDW'(1);
        sy_nxt = sy;
        if (line_end) begin
            sy_nxt = frame_end ? '0 : sy + CORDW'(1);
        end
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= CORDW'(H_TOTAL - 1);
            sy    <= CORDW'(V_TOTAL - 1);
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            hsync <= (sx_nxt >= HS_START) && (sx_nxt < HS_END);
            vsync <= (sy_nxt >= VS_START) && (sy_nxt < VS_END);  // whole lines
            de    <= (sx_nxt < H_ACTIVE) && (sy_nxt < V_ACTIVE);
            frame <= (sx_nxt == 0) && (sy_nxt == 0);
            line  <= (sx_nxt == 0);
        end
    end

endmodule

/* rtl/draw_line.sv */
// integer bresenham over all octants, one point per cycle, both ends drawn
// start is ignored while a line is in progress
`timescale 1ns/1ps

module draw_line import cube_pkg::*; (
    input  logic                    clk_100m,
    input  logic                    arst_n,
    input  logic                    start,
    input  logic signed [CORDW-1:0] x0,
    input  logic signed [CORDW-1:0] y0,
    input  logic signed [CORDW-1:0] x1,
    input  logic signed [CORDW-1:0] y1,
    output logic signed [CORDW-1:0] x,
    output logic signed [CORDW-1:0] y,
    output logic                    drawing,
    output logic                    done
);

    enum logic {IDLE, DRAW} state;

    logic signed [CORDW-1:0] x_end, y_end;
    logic signed [CORDW:0]   dx, dy;        // dy held negative
    logic signed [CORDW:0]   dx_in, dy_in;
    logic signed [CORDW+1:0] err;
    logic signed [CORDW+2:0] e2;
    logic                    right, down;   // step directions
    logic                    movx, movy;
    logic                    at_end;

    always_comb begin
        dx_in = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy_in = (y1 > y0) ? y0 - y1 : y1 - y0;
    end

    assign e2      = {err, 1'b0};
    assign movx    = (e2 >= dy);
    assign movy    = (e2 <= dx);
    assign at_end  = (x == x_end) && (y == y_end);
    assign drawing = (state == DRAW);

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            done  <= 1'b0;
            x     <= '0;
            y     <= '0;
            x_end <= '0;
            y_end <= '0;
            dx    <= '0;
            dy    <= '0;
            err   <= '0;
            right <= 1'b0;
            down  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= DRAW;
                        x     <= x0;
                        y     <= y0;
                        x_end <= x1;
                        y_end <= y1;
                        dx    <= dx_in;
                        dy    <= dy_in;
                        err   <= dx_in + dy_in;
                        right <= (x0 < x1);
                        down  <= (y0 < y1);
                    end
                end
                default: begin  // DRAW
                    if (at_end) begin
                        state <= IDLE;
                        done  <= 1'b1;  // cycle after the last point
                    end else begin
                        if (movx) begin
                            x <= right ? x + CORDW'(1) : x - CORDW'(1);
                        end
                        if (movy) begin
                            y <= down ? y + CORDW'(1) : y - CORDW'(1);
                        end
                        // both corrections apply on a diagonal step
                        err <= err + (movx ? dy : (CORDW+1)'(0))
                                   + (movy ? dx : (CORDW+1)'(0));
                    end
                end
            endcase
        end
    end

endmodule

/* rtl/framebuffer.sv */
// colour index ram with palette lookup, output is one cycle behind sx/sy
// ram has an asynchronous read so a write is visible on the next cycle
`timescale 1ns/1ps

module framebuffer import cube_pkg::*; (
    input  logic                    clk_100m,
    input  logic                    arst_n,
    input  logic                    we,
    input  logic signed [CORDW-1:0] wx,
    input  logic signed [CORDW-1:0] wy,
    input  logic [CIDXW-1:0]        wcidx,
    input  logic signed [CORDW-1:0] sx,
    input  logic signed [CORDW-1:0] sy,
    input  logic                    de_in,
    input  logic                    hsync_in,
    input  logic                    vsync_in,
    output logic [CHANW-1:0]        red,
    output logic [CHANW-1:0]        green,
    output logic [CHANW-1:0]        blue,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de
);

    logic [CIDXW-1:0]    mem [FB_DEPTH];
    logic [FB_ADDRW-1:0] waddr;
    logic [FB_ADDRW-1:0] raddr;
    logic                wr_ok;
    logic [3*CHANW-1:0]  rgb;

    // background is colour index 0
    initial begin
        for (int i = 0; i < FB_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign wr_ok = we && (wx >= 0) && (wx < FB_WIDTH) && (wy >= 0) && (wy < FB_HEIGHT);
    assign waddr = FB_ADDRW'(wy * FB_WIDTH + wx);
    assign raddr = FB_ADDRW'(sy * FB_WIDTH + sx);  // only meaningful while de_in

    always_ff @(posedge clk_100m) begin
        if (wr_ok) begin
            mem[waddr] <= wcidx;    // off-screen points are dropped
        end
    end

    assign rgb = PALETTE[mem[raddr]];

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            hsync <= hsync_in;
            vsync <= vsync_in;
            de    <= de_in;
            // black outside the active area
            red   <= de_in ? rgb[3*CHANW-1:2*CHANW] : '0;
            green <= de_in ? rgb[2*CHANW-1:CHANW]   : '0;
            blue  <= de_in ? rgb[CHANW-1:0]         : '0;
        end
    end

endmodule

/* include/tb_cube_model.svh */
// reference model for the cube image, included inside a module importing cube_pkg
// bresenham steps mirror draw_line so ties resolve to the same pixels
`ifndef TB_CUBE_MODEL_SVH
`define TB_CUBE_MODEL_SVH

logic [CIDXW-1:0] model_img [FB_DEPTH];   // expected colour index per pixel

function automatic void plot_pixel(int px, int py, logic [CIDXW-1:0] cidx);
    if (px >= 0 && px < FB_WIDTH && py >= 0 && py < FB_HEIGHT) begin
        model_img[py * FB_WIDTH + px] = cidx;
    end
endfunction

function automatic void rasterise_line(int x0, int y0, int x1, int y1,
                                       logic [CIDXW-1:0] cidx);
    int dx, dy, err, e2, stx, sty, x, y;
    dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy  = (y1 > y0) ? y0 - y1 : y1 - y0;    // negative, as in the rtl
    stx = (x0 < x1) ? 1 : -1;
    sty = (y0 < y1) ? 1 : -1;
    err = dx + dy;
    x   = x0;
    y   = y0;
    forever begin
        plot_pixel(x, y, cidx);
        if (x == x1 && y == y1) break;
        e2 = 2 * err;
        if (e2 >= dy) begin
            err += dy;
            x += stx;
        end
        if (e2 <= dx) begin
            err += dx;
            y += sty;
        end
    end
endfunction

// clear to background, then draw every edge, later writes win
function automatic void build_image(logic [CIDXW-1:0] cidx);
    for (int i = 0; i < FB_DEPTH; i++) begin
        model_img[i] = '0;
    end
    for (int e = 0; e < LINE_CNT; e++) begin
        rasterise_line(CUBE_EDGES[e][0], CUBE_EDGES[e][1],
                       CUBE_EDGES[e][2], CUBE_EDGES[e][3], cidx);
    end
endfunction

// expected {red, green, blue} at a pixel
function automatic logic [3*CHANW-1:0] expected_rgb(int px, int py);
    return PALETTE[model_img[py * FB_WIDTH + px]];
endfunction

`endif

/* testbench/tb_cube_display.sv */
// self-checking testbench for the cube display, one pixel per clock at 100 MHz
// frames are captured from the video outputs and compared with the reference model
`timescale 1ns/1ps

module tb_cube_display import cube_pkg::*; ();

    localparam int               FRAME_CYC  = H_TOTAL * V_TOTAL;
    localparam logic [CIDXW-1:0] RESET_CIDX = 4'd8;     // colour after reset
    localparam int               BUSY_PULSE = 100;      // well inside one pass

    logic             clk_100m;
    logic             arst_n;
    logic             redraw;
    logic [CIDXW-1:0] draw_cidx;
    logic             hsync, vsync, de;
    logic [CHANW-1:0] red, green, blue;
    logic             busy, finished;

    int n_checks = 0;
    int n_errors = 0;

    `include "tb_cube_model.svh"

    cube_display_top cube_display_top_inst (
        .clk_100m  (clk_100m),
        .arst_n    (arst_n),
        .redraw    (redraw),
        .draw_cidx (draw_cidx),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .busy      (busy),
        .finished  (finished)
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic abort_run(string why);
        $display("ERROR: %s (after %0d errors)", why, n_errors);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // counts frame starts seen on de until busy rises
    task automatic wait_busy(output int starts);
        int  t;
        int  low_run;
        logic prev_de;
        starts  = 0;
        low_run = 2 * H_TOTAL;      // reset counts as blanking
        prev_de = 1'b0;
        for (t = 0; t < (DRAW_WAIT + 3) * FRAME_CYC; t++) begin
            @(negedge clk_100m);
            if (de && !prev_de && low_run > H_TOTAL) starts++;
            low_run = de ? 0 : low_run + 1;
            prev_de = de;
            if (busy) return;
        end
        abort_run("busy never rose, drawing did not start");
    endtask

    task automatic wait_finished();
        int t;
        for (t = 0; t < 2 * FRAME_CYC; t++) begin
            @(negedge clk_100m);
            if (finished) return;
        end
        abort_run("finished never rose, drawing did not complete");
    endtask

    task automatic wait_vsync_fall();
        int   t;
        logic prev;
        prev = 1'b0;
        for (t = 0; t < 2 * FRAME_CYC; t++) begin
            @(negedge clk_100m);
            if (prev && !vsync) return;
            prev = vsync;
        end
        abort_run("vsync did not fall within two frames");
    endtask

    // one full frame window starting at a vsync fall
    task automatic measure_raster();
        int t;
        int de_cnt, de_len, de_runs;
        int hs_cnt, hs_len, vs_cnt;
        de_cnt  = 0;
        de_len  = 0;
        de_runs = 0;
        hs_cnt  = 0;
        hs_len  = 0;
        vs_cnt  = 0;
        wait_vsync_fall();
        for (t = 0; t < FRAME_CYC; t++) begin
            if (t > 0) @(negedge clk_100m);
            if (de) begin
                de_cnt++;
                de_len++;
            end else if (de_len != 0) begin
                check_value("de_run_length", de_len, H_ACTIVE);
                de_runs++;
                de_len = 0;
            end
            if (hsync) begin
                hs_cnt++;
                hs_len++;
            end else if (hs_len != 0) begin
                check_value("hsync_pulse_length", hs_len, H_SYNC);
                hs_len = 0;
            end
            if (vsync) vs_cnt++;
        end
        check_value("de_cycles", de_cnt, H_ACTIVE * V_ACTIVE);
        check_value("de_runs", de_runs, V_ACTIVE);
        check_value("hsync_cycles", hs_cnt, H_SYNC * V_TOTAL);
        check_value("vsync_cycles", vs_cnt, V_SYNC * H_TOTAL);  // whole lines
    endtask

    // scan order capture, pixel n of the frame is the n-th cycle with de high
    task automatic capture_frame(logic [CIDXW-1:0] cidx);
        int idx;
        int t;
        build_image(cidx);
        wait_vsync_fall();
        idx = 0;
        for (t = 0; t < FRAME_CYC && idx < FB_DEPTH; t++) begin
            @(negedge clk_100m);
            if (de) begin
                check_value($sformatf("rgb[%0d,%0d]", idx % FB_WIDTH, idx / FB_WIDTH),
                            {red, green, blue},
                            expected_rgb(idx % FB_WIDTH, idx / FB_WIDTH));
                idx++;
            end
        end
        if (idx < FB_DEPTH) begin
            abort_run("frame capture ended before all pixels arrived");
        end else begin
            check_value("finished", finished, 1'b1);
        end
    endtask

    // redraw noise while a pass is running, must not be accepted
    task automatic pulse_while_busy(int cycles);
        repeat (cycles) begin
            @(posedge clk_100m);
            redraw    <= ($urandom_range(0, 3) == 0);
            draw_cidx <= CIDXW'($urandom_range(0, 15));
            @(negedge clk_100m);
            check_value("busy", busy, 1'b1);
        end
        @(posedge clk_100m);
        redraw <= 1'b0;
    endtask

    task automatic request_redraw(logic [CIDXW-1:0] cidx);
        check_value("finished", finished, 1'b1);
        @(posedge clk_100m);
        redraw    <= 1'b1;
        draw_cidx <= cidx;
        @(posedge clk_100m);
        redraw    <= 1'b0;
        draw_cidx <= CIDXW'($urandom_range(0, 15));     // sampled only on accept
        @(negedge clk_100m);
        check_value("finished", finished, 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge clk_100m);
        arst_n <= 1'b0;
        @(negedge clk_100m);
        check_value("busy", busy, 1'b0);
        check_value("finished", finished, 1'b0);
        repeat (2) @(posedge clk_100m);
        arst_n <= 1'b1;
    endtask

    task automatic check_reset_state();
        @(negedge clk_100m);
        check_value("busy", busy, 1'b0);
        check_value("finished", finished, 1'b0);
        check_value("hsync", hsync, 1'b0);
        check_value("vsync", vsync, 1'b0);
        check_value("de", de, 1'b0);
    endtask

    initial begin
        int               starts;
        int               round;
        int               delay;
        logic [CIDXW-1:0] cidx;
        void'($urandom(32'h0d1bddd0));
        arst_n    = 1'b0;
        redraw    = 1'b0;
        draw_cidx = '0;
        repeat (2) @(posedge clk_100m);
        arst_n <= 1'b1;
        check_reset_state();

        // first pass, frame starts counted up to busy
        wait_busy(starts);
        check_value("frames_before_busy_ok", starts >= DRAW_WAIT, 1'b1);
        pulse_while_busy(BUSY_PULSE);
        wait_finished();
        capture_frame(RESET_CIDX);
        measure_raster();
        capture_frame(RESET_CIDX);      // ignored redraws left it unchanged

        for (round = 0; round < 4; round++) begin
            cidx = CIDXW'($urandom_range(1, 15));
            request_redraw(cidx);
            wait_busy(starts);
            pulse_while_busy(BUSY_PULSE);
            wait_finished();
            capture_frame(cidx);
        end

        // reset somewhere inside a pass
        request_redraw(CIDXW'($urandom_range(1, 15)));
        wait_busy(starts);
        delay = $urandom_range(1, 300);
        repeat (delay) @(negedge clk_100m);
        check_value("busy_before_reset", busy, 1'b1);
        apply_reset();
        check_reset_state();
        wait_busy(starts);
        check_value("frames_before_busy_ok", starts >= DRAW_WAIT, 1'b1);
        wait_finished();
        capture_frame(RESET_CIDX);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
